// ==== id_decoder.sv ====
module id_decoder (
    input  logic [id_pkg::xlen-1:0] instr_i,
    output id_pkg::id_ctrl_t        ctrl_o
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    id_pkg::imm_sel_e imm_sel;
    id_pkg::id_ctrl_t ctrl;     // everything but the immediate

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // ========================================================================
    // opcode / funct decode
    // ========================================================================
    always_comb begin
        ctrl     = '0;              // add, no mem op, no flags
        ctrl.rd  = instr_i[11:7];
        ctrl.rs1 = instr_i[19:15];
        ctrl.rs2 = instr_i[24:20];
        imm_sel  = id_pkg::imm_i;
        case (opcode)
            id_pkg::opc_lui: begin
                ctrl.alu_op   = id_pkg::alu_pass_b;   // rd = imm
                ctrl.b_is_imm = 1'b1;
                ctrl.wb_en    = 1'b1;
                imm_sel       = id_pkg::imm_u;
            end
            id_pkg::opc_auipc: begin
                ctrl.a_is_pc  = 1'b1;                 // pc + imm
                ctrl.b_is_imm = 1'b1;
                ctrl.wb_en    = 1'b1;
                imm_sel       = id_pkg::imm_u;
            end
            id_pkg::opc_jal: begin
                ctrl.a_is_pc  = 1'b1;                 // alu forms the target
                ctrl.b_is_imm = 1'b1;
                ctrl.is_jal   = 1'b1;
                ctrl.wb_en    = 1'b1;                 // link written by execute
                imm_sel       = id_pkg::imm_j;
            end
            id_pkg::opc_jalr: begin
                ctrl.b_is_imm = 1'b1;                 // rs1 + imm
                ctrl.is_jalr  = 1'b1;
                ctrl.wb_en    = 1'b1;
                ctrl.illegal  = (funct3 != 3'b000);
            end
            id_pkg::opc_branch: begin
                ctrl.is_branch = 1'b1;                // rs1 vs rs2, no write-back
                imm_sel        = id_pkg::imm_b;
                case (funct3)
                    3'b000, 3'b001: ctrl.alu_op = id_pkg::alu_sub;   // beq bne
                    3'b100, 3'b101: ctrl.alu_op = id_pkg::alu_slt;   // blt bge
                    3'b110, 3'b111: ctrl.alu_op = id_pkg::alu_sltu;  // bltu bgeu
                    default:        ctrl.illegal = 1'b1;
                endcase
            end
            id_pkg::opc_load: begin
                ctrl.b_is_imm = 1'b1;                 // address = rs1 + imm
                ctrl.wb_en    = 1'b1;
                case (funct3)
                    3'b000:  ctrl.mem_op = id_pkg::mem_lb;
                    3'b001:  ctrl.mem_op = id_pkg::mem_lh;
                    3'b010:  ctrl.mem_op = id_pkg::mem_lw;
                    3'b100:  ctrl.mem_op = id_pkg::mem_lbu;
                    3'b101:  ctrl.mem_op = id_pkg::mem_lhu;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            id_pkg::opc_store: begin
                ctrl.b_is_imm = 1'b1;
                imm_sel       = id_pkg::imm_s;
                case (funct3)
                    3'b000:  ctrl.mem_op = id_pkg::mem_sb;
                    3'b001:  ctrl.mem_op = id_pkg::mem_sh;
                    3'b010:  ctrl.mem_op = id_pkg::mem_sw;
                    default: ctrl.illegal = 1'b1;
                endcase
            end
            id_pkg::opc_op_imm: begin
                ctrl.b_is_imm = 1'b1;
                ctrl.wb_en    = 1'b1;
                case (funct3)
                    3'b000: ctrl.alu_op = id_pkg::alu_add;
                    3'b010: ctrl.alu_op = id_pkg::alu_slt;
                    3'b011: ctrl.alu_op = id_pkg::alu_sltu;
                    3'b100: ctrl.alu_op = id_pkg::alu_xor;
                    3'b110: ctrl.alu_op = id_pkg::alu_or;
                    3'b111: ctrl.alu_op = id_pkg::alu_and;
                    3'b001: begin                     // shamt in imm[4:0]
                        ctrl.alu_op  = id_pkg::alu_sll;
                        ctrl.illegal = (funct7 != 7'h00);
                    end
                    default: begin                    // 3'b101, srli / srai
                        ctrl.alu_op  = funct7[5] ? id_pkg::alu_sra : id_pkg::alu_srl;
                        ctrl.illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
                    end
                endcase
            end
            id_pkg::opc_op: begin
                ctrl.wb_en = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: ctrl.alu_op = id_pkg::alu_add;
                    {7'h20, 3'b000}: ctrl.alu_op = id_pkg::alu_sub;
                    {7'h00, 3'b001}: ctrl.alu_op = id_pkg::alu_sll;
                    {7'h00, 3'b010}: ctrl.alu_op = id_pkg::alu_slt;
                    {7'h00, 3'b011}: ctrl.alu_op = id_pkg::alu_sltu;
                    {7'h00, 3'b100}: ctrl.alu_op = id_pkg::alu_xor;
                    {7'h00, 3'b101}: ctrl.alu_op = id_pkg::alu_srl;
                    {7'h20, 3'b101}: ctrl.alu_op = id_pkg::alu_sra;
                    {7'h00, 3'b110}: ctrl.alu_op = id_pkg::alu_or;
                    {7'h00, 3'b111}: ctrl.alu_op = id_pkg::alu_and;
                    default:         ctrl.illegal = 1'b1;
                endcase
            end
            default: ctrl.illegal = 1'b1;             // outside the subset
        endcase

        // an illegal instr must not touch state downstream
        if (ctrl.illegal) begin
            ctrl.wb_en  = 1'b0;
            ctrl.mem_op = id_pkg::mem_none;
        end
        if (ctrl.rd == '0) ctrl.wb_en = 1'b0;         // x0 writes dropped here
    end

    // ========================================================================
    // immediate extension
    // ========================================================================
    always_comb begin
        ctrl_o = ctrl;
        case (imm_sel)
            id_pkg::imm_s: ctrl_o.imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            id_pkg::imm_b: ctrl_o.imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                                         instr_i[30:25], instr_i[11:8], 1'b0};
            id_pkg::imm_u: ctrl_o.imm = {instr_i[31:12], 12'h000};
            id_pkg::imm_j: ctrl_o.imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                                         instr_i[20], instr_i[30:21], 1'b0};
            default:       ctrl_o.imm = {{20{instr_i[31]}}, instr_i[31:20]};  // i-type
        endcase
    end

endmodule

// ==== id_issue.sv ====
module id_issue (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 flush_i,
    input  logic                 in_valid_i,
    input  id_pkg::fetch_pkt_t   in_pkt_i,
    output logic                 in_ready_o,
    input  id_pkg::id_ctrl_t     ctrl_i,
    input  id_pkg::id_operands_t ops_i,
    input  logic                 rs1_depended_i,
    output logic                 out_valid_o,
    output id_pkg::issue_pkt_t   out_pkt_o,
    input  logic                 out_ready_i
);

    logic                    load;          // input transfer this cycle
    logic [id_pkg::xlen-1:0] op_a;
    logic [id_pkg::xlen-1:0] br_target;     // pc + imm
    logic [id_pkg::xlen-1:0] jalr_target;
    id_pkg::issue_pkt_t      next_pkt;

    // ========================================================================
    // operands and static prediction
    // ========================================================================
    assign br_target   = in_pkt_i.pc + ctrl_i.imm;
    assign jalr_target = (ops_i.rs1_val + ctrl_i.imm) & ~32'h1;

    always_comb begin
        if (ctrl_i.a_is_pc) op_a = in_pkt_i.pc;
        else if (ctrl_i.alu_op == id_pkg::alu_pass_b) op_a = '0;   // lui
        else op_a = ops_i.rs1_val;
    end

    always_comb begin
        next_pkt            = '0;
        next_pkt.pc         = in_pkt_i.pc;
        next_pkt.op_a       = op_a;
        next_pkt.op_b       = ctrl_i.b_is_imm ? ctrl_i.imm : ops_i.rs2_val;
        next_pkt.store_data = ops_i.rs2_val;
        next_pkt.imm        = ctrl_i.imm;
        next_pkt.alu_op     = ctrl_i.alu_op;
        next_pkt.mem_op     = ctrl_i.mem_op;
        next_pkt.is_branch  = ctrl_i.is_branch;
        next_pkt.is_jalr    = ctrl_i.is_jalr;
        next_pkt.wb_en      = ctrl_i.wb_en;
        next_pkt.rd         = ctrl_i.rd;
        next_pkt.illegal    = ctrl_i.illegal;
        next_pkt.pred_pc    = in_pkt_i.pc + 32'd4;             // fall through
        if (ctrl_i.is_jal || (ctrl_i.is_branch && ctrl_i.imm[31])) begin
            next_pkt.pred_taken = 1'b1;                        // jal, backward branch
            next_pkt.pred_pc    = br_target;
        end else if (ctrl_i.is_jalr && !rs1_depended_i) begin
            next_pkt.pred_taken = 1'b1;                        // rs1 already final
            next_pkt.pred_pc    = jalr_target;
        end
    end

    // ========================================================================
    // issue register
    // ========================================================================
    assign in_ready_o = !out_valid_o || out_ready_i;   // empty or draining
    assign load       = in_valid_i && in_ready_o;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            out_valid_o <= 1'b0;
        end else if (flush_i) begin
            out_valid_o <= 1'b0;                       // drop held and incoming
        end else if (load) begin
            out_valid_o <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            out_pkt_o         <= '0;
            out_pkt_o.pc      <= id_pkg::reset_pc;
            out_pkt_o.pred_pc <= id_pkg::reset_pc;
        end else if (load && !flush_i) begin
            out_pkt_o <= next_pkt;
        end
    end

    // stalled packet holds until execute takes it
    a_hold: assert property (@(posedge clk) disable iff (!resetn)
        out_valid_o && !out_ready_i && !flush_i |=> out_valid_o && $stable(out_pkt_o));

    // bad instr reaches execute with no side effects
    a_illegal_quiet: assert property (@(posedge clk) disable iff (!resetn)
        out_valid_o && out_pkt_o.illegal |->
            !out_pkt_o.wb_en && (out_pkt_o.mem_op == id_pkg::mem_none));

endmodule

// ==== id_operand_read.sv ====
module id_operand_read (
    input  logic                          clk,
    input  logic                          resetn,
    input  logic [id_pkg::reg_addr_w-1:0] rs1_i,
    input  logic [id_pkg::reg_addr_w-1:0] rs2_i,
    input  logic                          wb_en_i,
    input  logic [id_pkg::reg_addr_w-1:0] wb_rd_i,
    input  logic [id_pkg::xlen-1:0]       wb_data_i,
    input  id_pkg::byp_sel_e              src1_sel_i,
    input  id_pkg::byp_sel_e              src2_sel_i,
    input  logic [id_pkg::xlen-1:0]       byp_exe_i,
    input  logic [id_pkg::xlen-1:0]       byp_mem_i,
    output id_pkg::id_operands_t          ops_o
);

    logic [id_pkg::xlen-1:0] regs [1:31];   // x0 has no storage

    // write-back port
    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en_i && (wb_rd_i != '0)) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // regfile read with write-through, then the bypass pick
    function automatic logic [id_pkg::xlen-1:0] read_src(
        input logic [id_pkg::reg_addr_w-1:0] idx,
        input id_pkg::byp_sel_e              sel
    );
        logic [id_pkg::xlen-1:0] rf_val;
        if (idx == '0) rf_val = '0;                                  // x0
        else if (wb_en_i && (wb_rd_i == idx)) rf_val = wb_data_i;    // same-cycle write
        else rf_val = regs[idx];
        case (sel)
            id_pkg::byp_exe: return byp_exe_i;
            id_pkg::byp_mem: return byp_mem_i;
            default:         return rf_val;
        endcase
    endfunction

    always_comb begin
        ops_o.rs1_val = read_src(rs1_i, src1_sel_i);
        ops_o.rs2_val = read_src(rs2_i, src2_sel_i);
    end

    // hazard logic never drives the spare encoding
    a_sel_legal: assert property (@(posedge clk) disable iff (!resetn)
        (src1_sel_i inside {id_pkg::byp_regfile, id_pkg::byp_exe, id_pkg::byp_mem}) &&
        (src2_sel_i inside {id_pkg::byp_regfile, id_pkg::byp_exe, id_pkg::byp_mem}));

endmodule

// ==== id_pkg.sv ====
package id_pkg;

    // ========================================================================
    // widths and constants
    // ========================================================================
    localparam int xlen       = 32;     // data and pc width
    localparam int reg_addr_w = 5;      // 32 architectural registers

    localparam logic [xlen-1:0] reset_pc = 32'h8000_0000;  // pc of a cleared packet

    // major opcodes, instr[6:0]
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load   = 7'b0000011;
    localparam logic [6:0] opc_store  = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op     = 7'b0110011;

    // ========================================================================
    // control encodings
    // ========================================================================
    // branches reuse sub/slt/sltu for the compare
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt,
        alu_sltu, alu_xor, alu_srl, alu_sra,
        alu_or, alu_and,
        alu_pass_b          // lui only, result is op_b
    } alu_op_e;

    typedef enum logic [3:0] {
        mem_none,
        mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu,
        mem_sb, mem_sh, mem_sw
    } mem_op_e;

    typedef enum logic [2:0] {
        imm_i, imm_s, imm_b, imm_u, imm_j
    } imm_sel_e;

    // operand source picked by the hazard logic, 2'b11 unused
    typedef enum logic [1:0] {
        byp_regfile = 2'b00,
        byp_exe     = 2'b01,
        byp_mem     = 2'b10
    } byp_sel_e;

    // ========================================================================
    // packets
    // ========================================================================
    typedef struct packed {
        logic [xlen-1:0] instr;
        logic [xlen-1:0] pc;
    } fetch_pkt_t;

    typedef struct packed {
        alu_op_e               alu_op;
        mem_op_e               mem_op;
        logic                  a_is_pc;    // op_a from pc
        logic                  b_is_imm;   // op_b from imm
        logic                  is_branch;
        logic                  is_jal;
        logic                  is_jalr;
        logic                  wb_en;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic                  illegal;
        logic [xlen-1:0]       imm;        // sign extended
    } id_ctrl_t;

    typedef struct packed {
        logic [xlen-1:0] rs1_val;  // after bypass
        logic [xlen-1:0] rs2_val;
    } id_operands_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       op_a;
        logic [xlen-1:0]       op_b;
        logic [xlen-1:0]       store_data;  // bypassed rs2
        logic [xlen-1:0]       imm;
        alu_op_e               alu_op;
        mem_op_e               mem_op;
        logic                  is_branch;
        logic                  is_jalr;
        logic                  wb_en;
        logic [reg_addr_w-1:0] rd;
        logic                  illegal;
        logic                  pred_taken;
        logic [xlen-1:0]       pred_pc;
    } issue_pkt_t;

endpackage

// ==== id_stage.sv ====
module id_stage (
    input  logic                          clk,
    input  logic                          resetn,
    // fetch side
    input  logic                          in_valid_i,
    input  id_pkg::fetch_pkt_t            in_pkt_i,
    output logic                          in_ready_o,
    // execute side
    output logic                          out_valid_o,
    output id_pkg::issue_pkt_t            out_pkt_o,
    input  logic                          out_ready_i,
    // write-back port
    input  logic                          wb_en_i,
    input  logic [id_pkg::reg_addr_w-1:0] wb_rd_i,
    input  logic [id_pkg::xlen-1:0]       wb_data_i,
    // from hazard logic
    input  id_pkg::byp_sel_e              src1_sel_i,
    input  id_pkg::byp_sel_e              src2_sel_i,
    input  logic [id_pkg::xlen-1:0]       byp_exe_i,
    input  logic [id_pkg::xlen-1:0]       byp_mem_i,
    input  logic                          rs1_depended_i,
    input  logic                          flush_i
);

    id_pkg::id_ctrl_t     ctrl;   // decoder result
    id_pkg::id_operands_t ops;    // bypassed source values

    id_decoder u_decoder (
        .instr_i (in_pkt_i.instr),
        .ctrl_o  (ctrl)
    );

    // indices straight from the decoder, same cycle
    id_operand_read u_operand_read (
        .clk        (clk),
        .resetn     (resetn),
        .rs1_i      (ctrl.rs1),
        .rs2_i      (ctrl.rs2),
        .wb_en_i    (wb_en_i),
        .wb_rd_i    (wb_rd_i),
        .wb_data_i  (wb_data_i),
        .src1_sel_i (src1_sel_i),
        .src2_sel_i (src2_sel_i),
        .byp_exe_i  (byp_exe_i),
        .byp_mem_i  (byp_mem_i),
        .ops_o      (ops)
    );

    id_issue u_issue (
        .clk            (clk),
        .resetn         (resetn),
        .flush_i        (flush_i),
        .in_valid_i     (in_valid_i),
        .in_pkt_i       (in_pkt_i),
        .in_ready_o     (in_ready_o),
        .ctrl_i         (ctrl),
        .ops_i          (ops),
        .rs1_depended_i (rs1_depended_i),
        .out_valid_o    (out_valid_o),
        .out_pkt_o      (out_pkt_o),
        .out_ready_i    (out_ready_i)
    );

endmodule

// ==== run.sh ====
#!/bin/bash
# build and run with Verilator, then decide from the log
(verilator --binary --timing --assert -f vlog.f --top-module tb_id_stage -o tb_sim \
    && ./obj_dir/tb_sim) > sim.log 2>&1 || echo "Simulation failed" >> sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL (see sim.log)"; exit 1; } \
    || { echo "PASS"; exit 0; }

// ==== tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk,
    output logic resetn
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;         // 20 ns period
    end

    initial begin
        resetn = 1'b0;
        repeat (8) @(posedge clk);      // 8 cycles in reset
        resetn <= 1'b1;
    end

endmodule

// ==== tb_id_stage.sv ====
module tb_id_stage;
    timeunit 1ns;
    timeprecision 1ps;

    logic clk, resetn, in_valid_i, in_ready_o, out_valid_o, out_ready_i;
    id_pkg::fetch_pkt_t in_pkt_i;
    id_pkg::issue_pkt_t out_pkt_o;
    logic wb_en_i, rs1_depended_i, flush_i;
    logic [4:0] wb_rd_i;
    logic [31:0] wb_data_i, byp_exe_i, byp_mem_i, pc;
    id_pkg::byp_sel_e src1_sel_i, src2_sel_i;

    logic [31:0] regs_m [32];               // register model
    id_pkg::issue_pkt_t exp_q [$];          // expected packets, in order
    integer seed = 32'h9981207d;
    int cycles = 0;
    int ready_mode = 0;                     // 0 always ready, 1 random, 2 stalled

    tb_clock_gen u_clk (.clk(clk), .resetn(resetn));

    id_stage DUT (.*);

    task automatic check_val(string name, logic [255:0] got, logic [255:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_with(string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    // model read, same-cycle write-back wins
    function automatic logic [31:0] rf_read(logic [4:0] idx);
        if (idx == 5'd0) return 32'd0;
        if (wb_en_i && wb_rd_i == idx) return wb_data_i;
        return regs_m[idx];
    endfunction

    // ========================================================================
    // reference: expected issue packet from the decode rules
    // ========================================================================
    function automatic id_pkg::issue_pkt_t ref_pkt(logic [31:0] ins, logic [31:0] ipc,
        logic [31:0] r1, logic [31:0] r2, id_pkg::byp_sel_e s1, id_pkg::byp_sel_e s2,
        logic [31:0] exe, logic [31:0] mem, logic dep);
        id_pkg::issue_pkt_t p;
        logic [31:0] v1, v2, imm;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic a_pc, b_imm, jal, ill;
        v1 = (s1 == id_pkg::byp_exe) ? exe : (s1 == id_pkg::byp_mem) ? mem : r1;
        v2 = (s2 == id_pkg::byp_exe) ? exe : (s2 == id_pkg::byp_mem) ? mem : r2;
        f3 = ins[14:12];
        f7 = ins[31:25];
        imm = {{20{ins[31]}}, ins[31:20]};  // i-type unless changed
        p = '0;
        {a_pc, b_imm, jal, ill} = 4'b0000;
        p.rd = ins[11:7];
        case (ins[6:0])
            id_pkg::opc_lui: begin
                imm = {ins[31:12], 12'h0};
                {b_imm, p.wb_en, p.alu_op} = {2'b11, id_pkg::alu_pass_b};
            end
            id_pkg::opc_auipc: begin
                imm = {ins[31:12], 12'h0};
                {a_pc, b_imm, p.wb_en} = 3'b111;
            end
            id_pkg::opc_jal: begin
                imm = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                {a_pc, b_imm, jal, p.wb_en} = 4'b1111;
            end
            id_pkg::opc_jalr: {b_imm, p.is_jalr, p.wb_en, ill} = {3'b111, f3 != 3'd0};
            id_pkg::opc_branch: begin
                imm = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                p.is_branch = 1'b1;
                case (f3)
                    0, 1:    p.alu_op = id_pkg::alu_sub;
                    4, 5:    p.alu_op = id_pkg::alu_slt;
                    6, 7:    p.alu_op = id_pkg::alu_sltu;
                    default: ill = 1'b1;
                endcase
            end
            id_pkg::opc_load: begin
                {b_imm, p.wb_en} = 2'b11;
                case (f3)
                    0: p.mem_op = id_pkg::mem_lb;
                    1: p.mem_op = id_pkg::mem_lh;
                    2: p.mem_op = id_pkg::mem_lw;
                    4: p.mem_op = id_pkg::mem_lbu;
                    5: p.mem_op = id_pkg::mem_lhu;
                    default: ill = 1'b1;
                endcase
            end
            id_pkg::opc_store: begin
                imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
                b_imm = 1'b1;
                case (f3)
                    0: p.mem_op = id_pkg::mem_sb;
                    1: p.mem_op = id_pkg::mem_sh;
                    2: p.mem_op = id_pkg::mem_sw;
                    default: ill = 1'b1;
                endcase
            end
            id_pkg::opc_op_imm: begin
                {b_imm, p.wb_en} = 2'b11;
                case (f3)
                    2: p.alu_op = id_pkg::alu_slt;
                    3: p.alu_op = id_pkg::alu_sltu;
                    4: p.alu_op = id_pkg::alu_xor;
                    6: p.alu_op = id_pkg::alu_or;
                    7: p.alu_op = id_pkg::alu_and;
                    1: {p.alu_op, ill} = {id_pkg::alu_sll, f7 != 7'h00};
                    5: {p.alu_op, ill} = {f7[5] ? id_pkg::alu_sra : id_pkg::alu_srl,
                                          f7 != 7'h00 && f7 != 7'h20};
                    default: p.alu_op = id_pkg::alu_add;
                endcase
            end
            id_pkg::opc_op: begin
                p.wb_en = 1'b1;
                case ({f7, f3})
                    {7'h20, 3'd0}: p.alu_op = id_pkg::alu_sub;
                    {7'h00, 3'd1}: p.alu_op = id_pkg::alu_sll;
                    {7'h00, 3'd2}: p.alu_op = id_pkg::alu_slt;
                    {7'h00, 3'd3}: p.alu_op = id_pkg::alu_sltu;
                    {7'h00, 3'd4}: p.alu_op = id_pkg::alu_xor;
                    {7'h00, 3'd5}: p.alu_op = id_pkg::alu_srl;
                    {7'h20, 3'd5}: p.alu_op = id_pkg::alu_sra;
                    {7'h00, 3'd6}: p.alu_op = id_pkg::alu_or;
                    {7'h00, 3'd7}: p.alu_op = id_pkg::alu_and;
                    {7'h00, 3'd0}: p.alu_op = id_pkg::alu_add;
                    default:       ill = 1'b1;
                endcase
            end
            default: ill = 1'b1;
        endcase
        if (ill) {p.wb_en, p.mem_op} = {1'b0, id_pkg::mem_none};  // no side effects
        if (p.rd == 5'd0) p.wb_en = 1'b0;
        {p.pc, p.illegal, p.imm, p.store_data} = {ipc, ill, imm, v2};
        p.op_a = a_pc ? ipc : (ins[6:0] == id_pkg::opc_lui) ? 32'd0 : v1;
        p.op_b = b_imm ? imm : v2;
        p.pred_pc = ipc + 32'd4;
        if (jal || (p.is_branch && imm[31])) {p.pred_taken, p.pred_pc} = {1'b1, ipc + imm};
        else if (p.is_jalr && !dep) {p.pred_taken, p.pred_pc} = {1'b1, (v1 + imm) & ~32'h1};
        return p;
    endfunction

    // ========================================================================
    // compare process, timeout and model update
    // ========================================================================
    always @(posedge clk) begin
        cycles++;
        if (cycles >= 4000) begin
            fail_with("timeout: the test did not finish within 4000 cycles");
        end else if (resetn) begin
            // one-entry stage, so it is full exactly when a packet is owed
            check_val("out_valid_o", out_valid_o, exp_q.size() != 0);
            check_val("in_ready_o", in_ready_o, exp_q.size() == 0 || out_ready_i);
            if (out_valid_o && out_ready_i) begin
                if (exp_q.size() == 0) fail_with("a packet left the stage that was never sent");
                else check_val("out_pkt_o", out_pkt_o, exp_q.pop_front());
            end
            if (flush_i) exp_q.delete();                    // held and incoming dropped
            else if (in_valid_i && in_ready_o)
                exp_q.push_back(ref_pkt(in_pkt_i.instr, in_pkt_i.pc, rf_read(in_pkt_i.instr[19:15]),
                    rf_read(in_pkt_i.instr[24:20]), src1_sel_i, src2_sel_i, byp_exe_i,
                    byp_mem_i, rs1_depended_i));
            if (wb_en_i && wb_rd_i != 5'd0) regs_m[wb_rd_i] = wb_data_i;
        end
    end

    always @(posedge clk) begin
        if (ready_mode == 0) out_ready_i <= 1'b1;
        else if (ready_mode == 1) out_ready_i <= 1'($random(seed));   // back-pressure
        else out_ready_i <= 1'b0;
    end

    function automatic logic [31:0] rand_instr();
        logic [6:0]  opcs [10] = '{id_pkg::opc_lui, id_pkg::opc_auipc, id_pkg::opc_jal,
            id_pkg::opc_jalr, id_pkg::opc_branch, id_pkg::opc_load, id_pkg::opc_store,
            id_pkg::opc_op_imm, id_pkg::opc_op, 7'b1111111};      // last one unknown
        logic [31:0] r;
        r = $random(seed);
        r[6:0] = opcs[$unsigned($random(seed)) % 10];
        if (r[6:0] == id_pkg::opc_op) r[31:25] = {1'b0, r[30], 5'd0};  // mostly legal funct7
        return r;
    endfunction

    function automatic id_pkg::byp_sel_e pick_sel();
        logic [1:0] v;
        v = 2'($unsigned($random(seed)) % 3);
        return id_pkg::byp_sel_e'(v);
    endfunction

    // hold the packet until the stage takes it
    task automatic send(logic [31:0] ins);
        in_valid_i <= 1'b1;
        in_pkt_i <= '{instr: ins, pc: pc};
        src1_sel_i <= pick_sel();
        src2_sel_i <= pick_sel();
        byp_exe_i <= $random(seed);
        byp_mem_i <= $random(seed);
        rs1_depended_i <= 1'($random(seed));
        wb_en_i <= 1'($random(seed));   // write-through while decoding
        wb_rd_i <= 5'($random(seed));
        wb_data_i <= $random(seed);
        do @(posedge clk); while (!in_ready_o);
        in_valid_i <= 1'b0;
        wb_en_i <= 1'b0;
        pc = pc + 32'd4;
    endtask

    initial begin
        {in_valid_i, out_ready_i, wb_en_i, rs1_depended_i, flush_i} = 5'b01000;
        {in_pkt_i, wb_rd_i, wb_data_i, byp_exe_i, byp_mem_i} = '0;
        src1_sel_i = id_pkg::byp_regfile;
        src2_sel_i = id_pkg::byp_regfile;
        pc = id_pkg::reset_pc;
        for (int i = 0; i < 32; i++) regs_m[i] = 32'd0;
        @(posedge resetn);
        @(posedge clk);
        for (int i = 1; i < 32; i++) begin          // fill the register file
            wb_en_i <= 1'b1;
            wb_rd_i <= 5'(i);
            wb_data_i <= $random(seed);
            @(posedge clk);
        end
        wb_en_i <= 1'b0;
        repeat (300) send(rand_instr());            // full rate
        ready_mode <= 1;
        repeat (300) begin
            send(rand_instr());
            repeat ($unsigned($random(seed)) % 3) @(posedge clk);
        end
        ready_mode <= 0;
        repeat (3) @(posedge clk);
        ready_mode <= 2;
        repeat (2) @(posedge clk);
        send(rand_instr());                         // parked in the issue register
        in_valid_i <= 1'b1;
        in_pkt_i <= '{instr: rand_instr(), pc: pc};
        flush_i <= 1'b1;
        @(posedge clk);
        {in_valid_i, flush_i} <= 2'b00;
        ready_mode <= 0;
        repeat (5) @(posedge clk);
        in_valid_i <= 1'b1;                         // empty stage, input offered under flush
        in_pkt_i <= '{instr: rand_instr(), pc: pc};
        flush_i <= 1'b1;
        @(posedge clk);
        {in_valid_i, flush_i} <= 2'b00;
        repeat (3) @(posedge clk);
        repeat (20) send(rand_instr());
        repeat (5) @(posedge clk);
        if (exp_q.size() != 0) begin
            fail_with("accepted packets never came out of the stage");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

// ==== vlog.f ====
id_pkg.sv
id_decoder.sv
id_operand_read.sv
id_issue.sv
id_stage.sv
tb_clock_gen.sv
tb_id_stage.sv
